// ==== Makefile ====
# Verilator build and run for the frame-buffer display testbench

VERILATOR ?= verilator
TOP       ?= tb_fb_display
FILELIST  ?= fb_display.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ns
JOBS      ?= 0
VFLAGS    ?= --binary --assert -j $(JOBS) --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only --timing --assert --timescale $(TIMESCALE)
PASS_TEXT ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# pass only when the testbench prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== fb_display.f ====
src/fb_display_pkg.sv
src/line_draw_ctrl.sv
src/frame_buffer.sv
src/lcd_timing.sv
src/fb_display_top.sv
tb/tb_fb_display.sv

// ==== src/fb_display_pkg.sv ====
`default_nettype none

package fb_display_pkg;

    // --------------------------------------------------
    // horizontal timing, in pixel clocks
    // --------------------------------------------------
    localparam int H_DISP  = 16;    // visible pixels per line
    localparam int H_FRONT = 2;     // front porch
    localparam int H_SYNC  = 2;     // hsync pulse width
    localparam int H_BACK  = 2;     // back porch
    localparam int H_TOTAL = H_DISP + H_FRONT + H_SYNC + H_BACK;   // 22

    // --------------------------------------------------
    // vertical timing, in lines
    // --------------------------------------------------
    localparam int V_DISP  = 8;     // visible lines
    localparam int V_FRONT = 1;     // front porch
    localparam int V_SYNC  = 1;     // vsync pulse width
    localparam int V_BACK  = 1;     // back porch
    localparam int V_TOTAL = V_DISP + V_FRONT + V_SYNC + V_BACK;   // 11

    // --------------------------------------------------
    // frame buffer geometry
    // --------------------------------------------------
    localparam int FB_DEPTH = H_DISP * V_DISP;    // one word per visible pixel
    localparam int ADDR_W   = $clog2(FB_DEPTH);   // 7 bits for 128 words
    localparam int RGB_W    = 24;                 // 8:8:8 colour

    // draw controller states
    typedef enum logic [1:0] {
        ST_CLEAR = 2'd0,    // zero sweep after reset
        ST_IDLE  = 2'd1,    // waiting for a command
        ST_WRITE = 2'd2     // run in progress
    } draw_state_e;

endpackage

`default_nettype wire

// ==== src/fb_display_top.sv ====
`default_nettype none

module fb_display_top (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire  [15:0]                        x_pos,
    input  wire  [15:0]                        y_pos,
    input  wire  [23:0]                        pixel,
    input  wire  [23:0]                        len,
    input  wire                                enable,
    output wire                                sys_valid,
    output wire                                busy,
    output wire                                lcd_hs,
    output wire                                lcd_vs,
    output wire                                lcd_de,
    output wire  [fb_display_pkg::RGB_W-1:0]   lcd_rgb
);

    // --------------------------------------------------
    // draw side to frame buffer
    // --------------------------------------------------
    wire                               wr_en;
    wire [fb_display_pkg::ADDR_W-1:0]  wr_addr;
    wire [fb_display_pkg::RGB_W-1:0]   wr_data;

    // scan side
    wire [fb_display_pkg::ADDR_W-1:0]  rd_addr;
    wire [fb_display_pkg::RGB_W-1:0]   rd_data;

    line_draw_ctrl u_line_draw_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .x_pos      (x_pos),
        .y_pos      (y_pos),
        .pixel      (pixel),
        .len        (len),
        .enable     (enable),
        .sys_valid  (sys_valid),    // clear sweep done
        .busy       (busy),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    frame_buffer u_frame_buffer (
        .clk        (clk),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)       // one clock latency
    );

    lcd_timing u_lcd_timing (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_data    (rd_data),
        .rd_addr    (rd_addr),
        .lcd_hs     (lcd_hs),
        .lcd_vs     (lcd_vs),
        .lcd_de     (lcd_de),
        .lcd_rgb    (lcd_rgb)
    );

endmodule

`default_nettype wire

// ==== src/frame_buffer.sv ====
`default_nettype none

module frame_buffer (
    input  wire                                clk,
    input  wire                                wr_en,
    input  wire  [fb_display_pkg::ADDR_W-1:0]  wr_addr,
    input  wire  [fb_display_pkg::RGB_W-1:0]   wr_data,
    input  wire  [fb_display_pkg::ADDR_W-1:0]  rd_addr,
    output logic [fb_display_pkg::RGB_W-1:0]   rd_data     // valid one clock after rd_addr
);

    // --------------------------------------------------
    // storage, one word per visible pixel
    // --------------------------------------------------
    logic [fb_display_pkg::RGB_W-1:0] mem [0:fb_display_pkg::FB_DEPTH-1];

    // write and read in one process so a same-address
    // collision hands back the word from before the write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;    // draw or clear port
        end
        rd_data <= mem[rd_addr];        // scan port, old data on collision
    end

endmodule

`default_nettype wire

// ==== src/lcd_timing.sv ====
`default_nettype none

module lcd_timing (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire  [fb_display_pkg::RGB_W-1:0]   rd_data,    // from frame buffer
    output logic [fb_display_pkg::ADDR_W-1:0]  rd_addr,
    output logic                               lcd_hs,     // active low
    output logic                               lcd_vs,     // active low
    output logic                               lcd_de,
    output logic [fb_display_pkg::RGB_W-1:0]   lcd_rgb
);

    logic [$clog2(fb_display_pkg::H_TOTAL)-1:0] h_cnt;    // pixel in line
    logic [$clog2(fb_display_pkg::V_TOTAL)-1:0] v_cnt;    // line in frame
    logic h_last;
    logic v_last;
    logic active;       // pre-display visible region
    logic hsync;
    logic vsync;

    // --------------------------------------------------
    // region decode: active, front, sync, back
    // --------------------------------------------------
    assign h_last = (32'(h_cnt) == fb_display_pkg::H_TOTAL - 1);
    assign v_last = (32'(v_cnt) == fb_display_pkg::V_TOTAL - 1);
    assign active = (32'(h_cnt) < fb_display_pkg::H_DISP) &&
                    (32'(v_cnt) < fb_display_pkg::V_DISP);
    assign hsync  = (32'(h_cnt) >= fb_display_pkg::H_DISP + fb_display_pkg::H_FRONT) &&
                    (32'(h_cnt) <  fb_display_pkg::H_DISP + fb_display_pkg::H_FRONT +
                                   fb_display_pkg::H_SYNC);
    assign vsync  = (32'(v_cnt) >= fb_display_pkg::V_DISP + fb_display_pkg::V_FRONT) &&
                    (32'(v_cnt) <  fb_display_pkg::V_DISP + fb_display_pkg::V_FRONT +
                                   fb_display_pkg::V_SYNC);

    // --------------------------------------------------
    // scan counters, free running from reset
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;   // next line or new frame
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // read pointer, raster order through the buffer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr <= '0;
        end else if (h_last && v_last) begin
            rd_addr <= '0;                  // frame start
        end else if (active) begin
            rd_addr <= rd_addr + 1'b1;      // one word per visible pixel
        end
    end

    // --------------------------------------------------
    // output stage, one clock behind the counters
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lcd_de <= 1'b0;
            lcd_hs <= 1'b1;     // inactive
            lcd_vs <= 1'b1;
        end else begin
            lcd_de <= active;   // meets rd_data
            lcd_hs <= !hsync;
            lcd_vs <= !vsync;
        end
    end

    assign lcd_rgb = lcd_de ? rd_data : '0;    // black in blanking

    a_de_outside_sync: assert property (
        @(posedge clk) disable iff (!rst_n) lcd_de |-> (lcd_hs && lcd_vs)
    ) else $error("data enable overlaps a sync pulse");

endmodule

`default_nettype wire

// ==== src/line_draw_ctrl.sv ====
`default_nettype none

module line_draw_ctrl (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire  [15:0]                        x_pos,      // start column
    input  wire  [15:0]                        y_pos,      // start row
    input  wire  [23:0]                        pixel,      // run colour
    input  wire  [23:0]                        len,        // run length
    input  wire                                enable,     // command strobe
    output logic                               sys_valid,  // clear sweep done
    output logic                               busy,       // run in progress
    output logic                               wr_en,
    output logic [fb_display_pkg::ADDR_W-1:0]  wr_addr,
    output logic [fb_display_pkg::RGB_W-1:0]   wr_data
);

    fb_display_pkg::draw_state_e state;

    logic [fb_display_pkg::ADDR_W-1:0] cur_addr;    // sweep / run pointer
    logic [fb_display_pkg::RGB_W-1:0]  color;       // latched run colour
    logic [23:0]                       remain;      // pixels left in run
    logic [31:0]                       lin_addr;    // y*H_DISP + x, unwrapped
    logic                              accept;
    logic                              clear_last;

    // --------------------------------------------------
    // command decode
    // --------------------------------------------------
    assign lin_addr   = 32'(y_pos) * fb_display_pkg::H_DISP + 32'(x_pos);
    assign accept     = enable && sys_valid && !busy;   // strobe ignored otherwise
    assign clear_last = (state == fb_display_pkg::ST_CLEAR) &&
                        (32'(cur_addr) == fb_display_pkg::FB_DEPTH - 1);

    // --------------------------------------------------
    // control FSM
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= fb_display_pkg::ST_CLEAR;
            cur_addr  <= '0;
            remain    <= '0;
            sys_valid <= 1'b0;
        end else begin
            case (state)
                fb_display_pkg::ST_CLEAR: begin
                    cur_addr <= cur_addr + 1'b1;            // one word per clock
                    if (clear_last) begin
                        state     <= fb_display_pkg::ST_IDLE;
                        sys_valid <= 1'b1;                  // like sdram init done
                    end
                end
                fb_display_pkg::ST_IDLE: begin
                    if (accept && (len != '0)) begin        // len 0 writes nothing
                        state    <= fb_display_pkg::ST_WRITE;
                        cur_addr <= lin_addr[fb_display_pkg::ADDR_W-1:0];   // mod FB_DEPTH
                        remain   <= len;
                    end
                end
                fb_display_pkg::ST_WRITE: begin
                    cur_addr <= cur_addr + 1'b1;            // wraps at end of frame
                    remain   <= remain - 1'b1;
                    if (remain == 24'd1) begin
                        state <= fb_display_pkg::ST_IDLE;   // last pixel this cycle
                    end
                end
                default: begin
                    state <= fb_display_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // colour only matters while writing
    always_ff @(posedge clk) begin
        if (accept) begin
            color <= pixel;
        end
    end

    // --------------------------------------------------
    // memory write port
    // --------------------------------------------------
    assign busy    = (state == fb_display_pkg::ST_WRITE);
    assign wr_en   = (state != fb_display_pkg::ST_IDLE);   // clear or run
    assign wr_addr = cur_addr;
    assign wr_data = busy ? color : '0;                    // zero during sweep

    a_busy_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) busy |-> sys_valid
    ) else $error("busy raised before clear sweep finished");

    // idle with no command taken must stay write free
    a_no_write_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((state == fb_display_pkg::ST_IDLE) && !(accept && (len != '0))) |=> !wr_en
    ) else $error("write strobe seen after an idle cycle with no command");

endmodule

`default_nettype wire

// ==== tb/draw_patterns.txt ====
// columns: kind x y colour len, all hex
// kind d draws and checks the next frame, b draws with no wait, c probes colour at x y
d 0000 0000 ff0000 00000010
c 0005 0000 ff0000 00000000
d 000a 0002 00ff00 00000014
c 000f 0002 00ff00 00000000
c 0001 0003 00ff00 00000000
d 000f 0007 0000ff 00000005
c 0000 0000 0000ff 00000000
c 0004 0000 ff0000 00000000
d 0003 0004 123456 00000000
c 0003 0004 000000 00000000
b 0002 0005 abcdef 00000003
b 0006 0005 fedcba 00000002
d 0000 0006 a5a5a5 00000001
c 0002 0005 abcdef 00000000
c 0007 0005 fedcba 00000000
c 0000 0006 a5a5a5 00000000
d 0003 0010 777777 00000004
c 0003 0000 777777 00000000
c 0007 0000 ff0000 00000000
d 0014 0001 0f0f0f 00000002
c 0004 0002 0f0f0f 00000000
d 0000 0000 3c3c3c 00000080
c 000f 0007 3c3c3c 00000000
0 0000 0000 000000 00000000

// ==== tb/tb_fb_display.sv ====
`default_nettype none

module tb_fb_display;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int MAX_REC = 100;
    localparam int FRAME   = fb_display_pkg::H_TOTAL * fb_display_pkg::V_TOTAL;

    logic        clk;
    logic        rst_n;
    logic [15:0] x_pos;
    logic [15:0] y_pos;
    logic [23:0] pixel;
    logic [23:0] len;
    logic        enable;
    logic        sys_valid;
    logic        busy;
    logic        lcd_hs;
    logic        lcd_vs;
    logic        lcd_de;
    logic [23:0] lcd_rgb;

    logic [31:0] pat_mem [0:511];                           // five words per record
    logic [23:0] model [0:fb_display_pkg::FB_DEPTH-1];      // expected frame contents
    int          error_cnt;
    int          check_cnt;
    int          cycle_cnt;
    int          cycle_limit;
    string       test_name;
    int          cur_frame;     // vsync falls seen so far
    int          cmp_frame;     // frame under comparison, -1 for none
    int          de_cnt;        // visible pixels since vsync
    int          vs_cnt;
    int          hs_cnt;
    logic        vs_prev;
    logic        in_frame;
    logic        probe_on;
    logic        probe_hit;
    int          probe_addr;
    logic [23:0] probe_exp;

    fb_display_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .x_pos      (x_pos),
        .y_pos      (y_pos),
        .pixel      (pixel),
        .len        (len),
        .enable     (enable),
        .sys_valid  (sys_valid),
        .busy       (busy),
        .lcd_hs     (lcd_hs),
        .lcd_vs     (lcd_vs),
        .lcd_de     (lcd_de),
        .lcd_rgb    (lcd_rgb)
    );

    always #50 clk = ~clk;     // 100 ns period

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic tick();
        @(posedge clk);
        #10;                    // drive point after the edge
    endtask

    task automatic check_value(input string name, input logic [23:0] exp, input logic [23:0] act);
        check_cnt++;
        assert (act === exp) else begin
            error_cnt++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        check_cnt++;
        assert (act == exp) else begin
            error_cnt++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    function automatic logic [31:0] field(input int rec, input int pos);
        int w;
        w = 5 * rec + pos;
        return pat_mem[w[8:0]];
    endfunction

    // linear address of a start position, wrapped to the frame
    function automatic int start_addr(input int x, input int y);
        return (y * fb_display_pkg::H_DISP + x) % fb_display_pkg::FB_DEPTH;
    endfunction

    // compare the whole frame that starts after the next vsync
    task automatic compare_frame(input string name);
        test_name = name;
        cmp_frame = cur_frame + 1;
        while (cur_frame <= cmp_frame) begin
            tick();
        end
        cmp_frame = -1;
    endtask

    task automatic send_draw(input int x, input int y, input logic [23:0] colour, input int n,
                             input string name);
        int a;
        int k;
        int busy_cycles;
        x_pos  = x[15:0];
        y_pos  = y[15:0];
        pixel  = colour;
        len    = n[23:0];
        enable = 1'b1;
        tick();                                     // taken on this edge
        enable = 1'b0;
        for (k = 0; k < n; k++) begin
            a = (start_addr(x, y) + k) % fb_display_pkg::FB_DEPTH;
            model[a[fb_display_pkg::ADDR_W-1:0]] = colour;
        end
        check_count({name, " busy rise"}, (n > 0) ? 1 : 0, int'(busy));
        busy_cycles = 0;
        while (busy && busy_cycles <= n) begin
            if (busy_cycles == 0) begin             // strobe while busy, must be dropped
                x_pos  = 16'd0;
                y_pos  = 16'd0;
                pixel  = 24'hdead00;
                len    = 24'd9;
                enable = 1'b1;
            end else begin
                enable = 1'b0;
            end
            busy_cycles++;
            tick();
        end
        enable = 1'b0;
        check_count({name, " busy length"}, n, busy_cycles);
    endtask

    // --------------------------------------------------
    // scan monitor, sampled mid-cycle
    // --------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (vs_prev && !lcd_vs) begin           // vsync fall closes a frame
                if (in_frame) begin
                    check_count("visible cycles per frame", fb_display_pkg::FB_DEPTH, de_cnt);
                    check_count("vsync cycles per frame",
                                fb_display_pkg::V_SYNC * fb_display_pkg::H_TOTAL, vs_cnt);
                    check_count("hsync cycles per frame",
                                fb_display_pkg::H_SYNC * fb_display_pkg::V_TOTAL, hs_cnt);
                end
                in_frame = 1'b1;
                de_cnt   = 0;
                vs_cnt   = 0;
                hs_cnt   = 0;
                cur_frame++;
            end
            if (!lcd_vs) begin
                vs_cnt++;
            end
            if (!lcd_hs) begin
                hs_cnt++;                           // two per line
            end
            if (lcd_de) begin
                if (in_frame && cur_frame == cmp_frame) begin
                    check_value($sformatf("%s pixel %0d", test_name, de_cnt),
                                model[de_cnt[fb_display_pkg::ADDR_W-1:0]], lcd_rgb);
                    if (probe_on && de_cnt == probe_addr) begin
                        probe_hit = 1'b1;
                        check_value({test_name, " probe"}, probe_exp, lcd_rgb);
                    end
                end
                de_cnt++;                           // raster position
            end else begin
                check_value("rgb in blanking", 24'h0, lcd_rgb);
            end
            vs_prev = lcd_vs;
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int          n_rec;
        int          sum_len;
        int          r;
        logic [31:0] kind;
        logic [31:0] word;
        string       name;
        clk = 1'b0;
        rst_n = 1'b0;
        x_pos = 16'd0;
        y_pos = 16'd0;
        pixel = 24'd0;
        len = 24'd0;
        enable = 1'b0;
        error_cnt = 0;
        check_cnt = 0;
        cycle_cnt = 0;
        cur_frame = 0;
        cmp_frame = -1;
        de_cnt = 0;
        vs_cnt = 0;
        hs_cnt = 0;
        vs_prev = 1'b1;
        in_frame = 1'b0;
        probe_on = 1'b0;
        probe_hit = 1'b0;
        probe_addr = 0;
        probe_exp = 24'd0;
        test_name = "idle";
        for (r = 0; r < fb_display_pkg::FB_DEPTH; r++) begin
            model[r[fb_display_pkg::ADDR_W-1:0]] = 24'd0;   // cleared frame
        end
        for (r = 0; r < 512; r++) begin
            pat_mem[r[8:0]] = 32'd0;
        end
        $readmemh("tb/draw_patterns.txt", pat_mem);
        n_rec = 0;
        sum_len = 0;
        while (n_rec < MAX_REC && field(n_rec, 0) inside {32'hd, 32'hb, 32'hc}) begin
            sum_len += int'(field(n_rec, 4));
            n_rec++;
        end
        cycle_limit = 8 + fb_display_pkg::FB_DEPTH + sum_len + 3 * FRAME * (n_rec + 2) + 500;
        assert (n_rec > 0) else begin
            error_cnt++;
            $display("no records could be read from the pattern file");
        end

        // reset, then the clear sweep with one early strobe
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        pixel = 24'hffffff;
        len = 24'd7;
        r = 0;
        while (!sys_valid && r <= 2 * fb_display_pkg::FB_DEPTH) begin
            tick();
            r++;
            enable = (r == 5);                      // before sys_valid, ignored
        end
        enable = 1'b0;
        check_count("clear done cycles", fb_display_pkg::FB_DEPTH, r);
        compare_frame("clear");

        for (r = 0; r < n_rec; r++) begin
            kind = field(r, 0);
            word = field(r, 3);
            name = $sformatf("record %0d", r);
            if (kind == 32'hc) begin
                probe_addr = start_addr(int'(field(r, 1)), int'(field(r, 2)));
                probe_exp = word[23:0];
                probe_hit = 1'b0;
                probe_on = 1'b1;
                compare_frame(name);
                probe_on = 1'b0;
                assert (probe_hit) else begin
                    error_cnt++;
                    $display("%s: probe pixel was never scanned", name);
                end
            end else begin
                send_draw(int'(field(r, 1)), int'(field(r, 2)), word[23:0],
                          int'(field(r, 4)), name);
                if (kind == 32'hd) begin
                    compare_frame(name);
                end
            end
        end
        compare_frame("final");

        $display("Summary: %0d checks, %0d failed", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
